// File: logic/tcb_pkg.sv
// TCB subsystem shared definitions

package tcb_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  // byte address width
  localparam int unsigned ABW = 16;
  // data width
  localparam int unsigned DBW = 32;
  // byte enable count
  localparam int unsigned BEW = DBW / 8;

  typedef logic [ABW-1:0] adr_t;
  typedef logic [DBW-1:0] dat_t;
  typedef logic [BEW-1:0] ben_t;

  ////////////////////////////////////////
  // request and response
  ////////////////////////////////////////

  // request fields sampled on a transfer
  typedef struct packed {
    logic wen;
    adr_t adr;
    ben_t ben;
    dat_t wdt;
  } tcb_req_t;

  // response fields valid with the rsp strobe
  typedef struct packed {
    dat_t rdt;
    logic err;
  } tcb_rsp_t;

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  // 0 selects memory, 1 selects registers
  localparam int unsigned REG_SEL_BIT = 15;

  // identification word
  localparam dat_t REG_ID = 32'h7cb0_0001;

  // register index from address bits 3:2
  typedef logic [1:0] reg_idx_t;

  localparam reg_idx_t REG_SCRATCH = 2'd0;
  localparam reg_idx_t REG_COUNT   = 2'd1;
  localparam reg_idx_t REG_IDENT   = 2'd2;
  localparam reg_idx_t REG_NONE    = 2'd3;

endpackage : tcb_pkg

// File: logic/tcb_rsp_pipe.sv
// TCB fixed delay response pipeline

`timescale 1ns/100ps

module tcb_rsp_pipe #(
  // response delay in cycles, at least 1
  parameter int unsigned DLY = 1
) (
  input  logic              tcb,
  input  logic              reset,
  input  logic              trn,
  input  logic              wen,
  input  tcb_pkg::tcb_rsp_t dat,
  output logic              rsp,
  output tcb_pkg::tcb_rsp_t rsp_dat
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // pipeline stages
  ////////////////////////////////////////

  // valid bit per stage
  logic [DLY-1:0] pip_vld;
  // write flag per stage
  logic           pip_wen [DLY];
  // response payload per stage
  tcb_rsp_t       pip_dat [DLY];

  // valid line, the only state under reset
  always_ff @(posedge tcb) begin
    if (reset) begin
      pip_vld <= '0;
    end else begin
      pip_vld <= (pip_vld << 1) | DLY'(trn);
    end
  end

  // payload line
  always_ff @(posedge tcb) begin
    // first stage loads only on a transfer
    if (trn) begin
      pip_wen[0] <= wen;
      pip_dat[0] <= dat;
    end
    // remaining stages shift every cycle
    for (int i = 1; i < DLY; i++) begin
      pip_wen[i] <= pip_wen[i-1];
      pip_dat[i] <= pip_dat[i-1];
    end
  end

  ////////////////////////////////////////
  // output
  ////////////////////////////////////////

  assign rsp = pip_vld[DLY-1];

  // write responses carry no read data
  assign rsp_dat.rdt = pip_wen[DLY-1] ? '0 : pip_dat[DLY-1].rdt;
  assign rsp_dat.err = pip_dat[DLY-1].err;

endmodule : tcb_rsp_pipe

// File: logic/tcb_mem_sub.sv
// TCB memory subordinate

`timescale 1ns/100ps

module tcb_mem_sub #(
  // response delay in cycles
  parameter int unsigned DLY    = 2,
  // word address width
  parameter int unsigned MEM_AW = 10
) (
  input  logic              tcb,
  input  logic              reset,
  input  logic              trn,
  input  tcb_pkg::tcb_req_t req,
  output logic              rsp,
  output tcb_pkg::tcb_rsp_t rsp_dat
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // word index into the array
  typedef logic [MEM_AW-1:0] wad_t;

  // word array, no reset contents
  dat_t mem [2**MEM_AW];

  // word index from the byte address
  // upper bits alias
  wad_t wad;

  assign wad = req.adr[MEM_AW+1:2];

  ////////////////////////////////////////
  // write
  ////////////////////////////////////////

  // byte lanes update only where enabled
  always_ff @(posedge tcb) begin
    if (trn && req.wen) begin
      for (int b = 0; b < BEW; b++) begin
        if (req.ben[b]) begin
          mem[wad][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // read
  ////////////////////////////////////////

  // response formed in the transfer cycle
  tcb_rsp_t rd_dat;

  // whole word read, before this cycle's write lands
  assign rd_dat.rdt = mem[wad];
  // memory never flags an error
  assign rd_dat.err = 1'b0;

  ////////////////////////////////////////
  // response delay
  ////////////////////////////////////////

  tcb_rsp_pipe #(
    .DLY     (DLY)
  ) rsp_pipe (
    .tcb     (tcb),
    .reset   (reset),
    .trn     (trn),
    .wen     (req.wen),
    .dat     (rd_dat),
    .rsp     (rsp),
    .rsp_dat (rsp_dat)
  );

endmodule : tcb_mem_sub

// File: logic/tcb_reg_sub.sv
// TCB register subordinate

`timescale 1ns/100ps

module tcb_reg_sub #(
  // response delay in cycles
  parameter int unsigned DLY = 1
) (
  input  logic              tcb,
  input  logic              reset,
  input  logic              trn,
  input  tcb_pkg::tcb_req_t req,
  output logic              rsp,
  output tcb_pkg::tcb_rsp_t rsp_dat
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  // register index
  reg_idx_t idx;
  // address outside the register window
  logic     bad_adr;
  // write to a read-only register
  logic     bad_wen;
  // any error
  logic     err;

  assign idx     = req.adr[3:2];
  assign bad_adr = |req.adr[14:4];
  assign bad_wen = req.wen && (idx == REG_COUNT || idx == REG_IDENT);
  assign err     = bad_adr || (idx == REG_NONE) || bad_wen;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  // scratch word
  dat_t scratch;
  // transfers seen so far
  dat_t count;

  always_ff @(posedge tcb) begin
    if (reset) begin
      scratch <= '0;
      count   <= '0;
    end else if (trn) begin
      // every transfer counts, errors included
      count <= count + 1'b1;
      // scratch written per byte lane
      if (req.wen && !err && idx == REG_SCRATCH) begin
        for (int b = 0; b < BEW; b++) begin
          if (req.ben[b]) begin
            scratch[8*b +: 8] <= req.wdt[8*b +: 8];
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // read mux
  ////////////////////////////////////////

  // response formed in the transfer cycle
  tcb_rsp_t rd_dat;

  always_comb begin
    rd_dat.err = err;
    // erroneous reads return zero
    if (err) begin
      rd_dat.rdt = '0;
    end else begin
      case (idx)
        REG_SCRATCH: rd_dat.rdt = scratch;
        // count before this transfer
        REG_COUNT:   rd_dat.rdt = count;
        REG_IDENT:   rd_dat.rdt = REG_ID;
        default:     rd_dat.rdt = '0;
      endcase
    end
  end

  ////////////////////////////////////////
  // response delay
  ////////////////////////////////////////

  tcb_rsp_pipe #(
    .DLY     (DLY)
  ) rsp_pipe (
    .tcb     (tcb),
    .reset   (reset),
    .trn     (trn),
    .wen     (req.wen),
    .dat     (rd_dat),
    .rsp     (rsp),
    .rsp_dat (rsp_dat)
  );

endmodule : tcb_reg_sub

// File: logic/tcb_dec.sv
// TCB address decoder and response slot tracker

`timescale 1ns/100ps

module tcb_dec #(
  // memory response delay
  parameter int unsigned MEM_DLY = 2,
  // register response delay
  parameter int unsigned REG_DLY = 1
) (
  input  logic              tcb,
  input  logic              reset,
  // manager side
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  // subordinate transfer strobes
  output logic              mem_trn,
  output logic              reg_trn,
  // subordinate responses
  input  logic              mem_rsp,
  input  tcb_pkg::tcb_rsp_t mem_dat,
  input  logic              reg_rsp,
  input  tcb_pkg::tcb_rsp_t reg_dat,
  // merged response
  output logic              rsp,
  output tcb_pkg::tcb_rsp_t rsp_dat
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // slot line sizing
  ////////////////////////////////////////

  // zero delay is not supported
  if (MEM_DLY < 1 || REG_DLY < 1) begin : g_dly_check
    $error("response delays must be at least 1");
  end

  // busy line as long as the larger delay
  localparam int unsigned SLOTS = (MEM_DLY > REG_DLY) ? MEM_DLY : REG_DLY;

  // bit i marks the slot i+1 cycles after the next edge
  typedef logic [SLOTS-1:0] slot_t;

  // slot each subordinate would claim
  localparam slot_t MEM_SLOT = SLOTS'(1) << (MEM_DLY - 1);
  localparam slot_t REG_SLOT = SLOTS'(1) << (REG_DLY - 1);

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  // register block selected
  logic  sel_reg;
  // slot needed by the offered request
  slot_t need;
  // slot taken by an accepted transfer
  slot_t claim;
  // transfer on this edge
  logic  trn;

  assign sel_reg = req.adr[REG_SEL_BIT];
  assign need    = sel_reg ? REG_SLOT : MEM_SLOT;

  ////////////////////////////////////////
  // busy line
  ////////////////////////////////////////

  // future response slots already taken
  slot_t busy;

  // ready ignores vld
  // stall only on a slot collision
  assign rdy = ~|(busy & need);

  assign trn     = vld & rdy;
  assign mem_trn = trn & ~sel_reg;
  assign reg_trn = trn & sel_reg;

  assign claim = trn ? need : '0;

  // claim then advance one cycle
  // a delay of one never reaches the line
  always_ff @(posedge tcb) begin
    if (reset) begin
      busy <= '0;
    end else begin
      busy <= (busy | claim) >> 1;
    end
  end

  ////////////////////////////////////////
  // response merge
  ////////////////////////////////////////

  // at most one strobe per cycle by construction
  assign rsp = mem_rsp | reg_rsp;

  always_comb begin
    case ({reg_rsp, mem_rsp})
      2'b01:   rsp_dat = mem_dat;
      2'b10:   rsp_dat = reg_dat;
      // idle bus
      default: rsp_dat = '0;
    endcase
  end

endmodule : tcb_dec

// File: logic/tcb_subsystem.sv
// TCB subsystem top level

`timescale 1ns/100ps

module tcb_subsystem #(
  // memory response delay
  parameter int unsigned MEM_DLY = 2,
  // register response delay
  parameter int unsigned REG_DLY = 1,
  // memory word address width
  parameter int unsigned MEM_AW  = 10
) (
  input  logic              tcb,
  input  logic              reset,
  // manager port
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output logic              rsp,
  output tcb_pkg::tcb_rsp_t rsp_dat
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////

  // memory branch
  logic     mem_trn;
  logic     mem_rsp;
  tcb_rsp_t mem_dat;

  // register branch
  logic     reg_trn;
  logic     reg_rsp;
  tcb_rsp_t reg_dat;

  ////////////////////////////////////////
  // decoder
  ////////////////////////////////////////

  tcb_dec #(
    .MEM_DLY (MEM_DLY),
    .REG_DLY (REG_DLY)
  ) dec (
    .tcb     (tcb),
    .reset   (reset),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .mem_trn (mem_trn),
    .reg_trn (reg_trn),
    .mem_rsp (mem_rsp),
    .mem_dat (mem_dat),
    .reg_rsp (reg_rsp),
    .reg_dat (reg_dat),
    .rsp     (rsp),
    .rsp_dat (rsp_dat)
  );

  // word memory
  tcb_mem_sub #(
    .DLY     (MEM_DLY),
    .MEM_AW  (MEM_AW)
  ) mem_sub (
    .tcb     (tcb),
    .reset   (reset),
    .trn     (mem_trn),
    .req     (req),
    .rsp     (mem_rsp),
    .rsp_dat (mem_dat)
  );

  // register block
  tcb_reg_sub #(
    .DLY     (REG_DLY)
  ) reg_sub (
    .tcb     (tcb),
    .reset   (reset),
    .trn     (reg_trn),
    .req     (req),
    .rsp     (reg_rsp),
    .rsp_dat (reg_dat)
  );

endmodule : tcb_subsystem

// File: test/tcb_clk_gen.sv
// TCB testbench clock source

`timescale 1ns/100ps

module tcb_clk_gen #(
  // clock period in ns
  parameter realtime PERIOD = 8.0
) (
  output logic tcb
);

  // starts low, first rising edge at half a period
  initial begin
    tcb = 1'b0;
  end

  always begin
    #(PERIOD / 2.0);
    tcb = ~tcb;
  end

endmodule : tcb_clk_gen

// File: test/tcb_subsystem_assert.sv
// TCB decoder assertions

`timescale 1ns/100ps

module tcb_dec_assert (
  input logic tcb,
  input logic reset,
  input logic vld,
  input logic rdy,
  input logic mem_trn,
  input logic reg_trn,
  input logic mem_rsp,
  input logic reg_rsp,
  input logic rsp
);

  ////////////////////////////////////////
  // response side
  ////////////////////////////////////////

  // one subordinate answers per cycle
  a_one_rsp: assert property (@(posedge tcb) !(mem_rsp && reg_rsp))
    else $error("memory and register responses in the same cycle");

  // response line quiet from the first reset edge on
  a_rsp_reset: assert property (@(posedge tcb) reset |=> !rsp)
    else $error("response strobe high during reset");

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////

  // one target per transfer
  a_one_trn: assert property (@(posedge tcb) !(mem_trn && reg_trn))
    else $error("both transfer strobes high");

  // strobes only on a handshake
  a_trn_hs: assert property (@(posedge tcb) (mem_trn || reg_trn) |-> (vld && rdy))
    else $error("transfer strobe without vld and rdy");

endmodule : tcb_dec_assert

bind tcb_dec tcb_dec_assert dec_assert (
  .tcb     (tcb),
  .reset   (reset),
  .vld     (vld),
  .rdy     (rdy),
  .mem_trn (mem_trn),
  .reg_trn (reg_trn),
  .mem_rsp (mem_rsp),
  .reg_rsp (reg_rsp),
  .rsp     (rsp)
);

// File: test/tcb_subsystem_tb.sv
// TCB subsystem testbench

`timescale 1ns/100ps

module tcb_subsystem_tb;

  import tcb_pkg::*;

  ////////////////////////////////////////
  // run setup
  ////////////////////////////////////////

  localparam int unsigned MEM_DLY     = 2;
  localparam int unsigned REG_DLY     = 1;
  localparam int unsigned MEM_AW      = 10;
  // accepted transfers in the run
  localparam int unsigned N_TRN       = 400;
  localparam realtime     CLK_PERIOD  = 8.0;
  // worst case per transfer plus reset and drain
  localparam int unsigned TIMEOUT_CYC = N_TRN * (MEM_DLY + 2) + 100;

  // expected response with rdt compared under msk
  typedef struct packed {
    dat_t        rdt;
    dat_t        msk;
    logic        err;
    int unsigned cyc;
  } exp_t;

  logic     tcb;
  logic     reset;
  logic     vld;
  tcb_req_t req;
  logic     rdy;
  logic     rsp;
  tcb_rsp_t rsp_dat;

  tcb_clk_gen #(.PERIOD(CLK_PERIOD)) clk_gen (.tcb(tcb));

  tcb_subsystem #(
    .MEM_DLY (MEM_DLY),
    .REG_DLY (REG_DLY),
    .MEM_AW  (MEM_AW)
  ) dut (
    .tcb     (tcb),
    .reset   (reset),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .rsp     (rsp),
    .rsp_dat (rsp_dat)
  );

  ////////////////////////////////////////
  // model state
  ////////////////////////////////////////

  // written memory bytes keyed by word*4+lane
  logic [7:0]  mem_model [int unsigned];
  dat_t        scratch_model;
  dat_t        count_model;
  // responses still owed with the oldest first
  exp_t        exp_q [$];
  // cycles whose response slot is claimed
  bit          slot_taken [int unsigned];
  // edges since reset release
  int unsigned cyc;
  // handshake seen at the last edge
  logic        taken;
  logic        last_mem_acc;
  int unsigned n_issued;
  int unsigned n_stall;

  ////////////////////////////////////////
  // failure and compare
  ////////////////////////////////////////

  task automatic end_with_failure();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      end_with_failure();
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  function automatic tcb_req_t make_req();
    tcb_req_t r;
    r     = '0;
    r.wen = $urandom % 2;
    r.ben = $urandom;
    r.wdt = $urandom;
    if ($urandom % 2) begin
      // register block with an occasional out of window address
      r.adr[REG_SEL_BIT] = 1'b1;
      r.adr[3:0]         = $urandom;
      if ($urandom % 8 == 0) begin
        r.adr[4 + ($urandom % 11)] = 1'b1;
      end
    end else begin
      // small word range so reads hit writes
      r.adr[5:0] = $urandom;
      // alias bits above the array
      if ($urandom % 4 == 0) begin
        r.adr[14:MEM_AW+2] = $urandom;
      end
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic exp_t apply_model(input tcb_req_t r);
    exp_t        e;
    int unsigned wad;
    reg_idx_t    idx;
    e     = '0;
    e.msk = '1;
    if (!r.adr[REG_SEL_BIT]) begin
      wad = r.adr[MEM_AW+1:2];
      for (int b = 0; b < BEW; b++) begin
        if (r.wen && r.ben[b]) begin
          mem_model[wad*BEW + b] = r.wdt[8*b +: 8];
        end else if (!r.wen && mem_model.exists(wad*BEW + b)) begin
          e.rdt[8*b +: 8] = mem_model[wad*BEW + b];
        end else if (!r.wen) begin
          // never written so not compared
          e.msk[8*b +: 8] = 8'h00;
        end
      end
    end else begin
      idx   = r.adr[3:2];
      e.err = (|r.adr[14:4]) || idx == 2'd3 || (r.wen && (idx == 2'd1 || idx == 2'd2));
      if (!e.err && r.wen) begin
        for (int b = 0; b < BEW; b++) begin
          if (r.ben[b]) begin
            scratch_model[8*b +: 8] = r.wdt[8*b +: 8];
          end
        end
      end else if (!e.err) begin
        case (idx)
          2'd0:    e.rdt = scratch_model;
          2'd1:    e.rdt = count_model;
          default: e.rdt = REG_ID;
        endcase
      end
      // every register transfer counts
      count_model = count_model + 1;
    end
    return e;
  endfunction

  ////////////////////////////////////////
  // monitor at the rising edge
  ////////////////////////////////////////

  always @(posedge tcb) begin
    exp_t        e;
    int unsigned dly;
    if (reset) begin
      cyc          = 0;
      taken        = 1'b0;
      last_mem_acc = 1'b0;
    end else begin
      if (rsp) begin
        if (exp_q.size() == 0) begin
          $display("unexpected response with no transfer outstanding at %0t", $time);
          end_with_failure();
        end else begin
          e = exp_q.pop_front();
          check("rsp cycle", cyc, e.cyc);
          check("rsp_dat.rdt", rsp_dat.rdt & e.msk, e.rdt & e.msk);
          check("rsp_dat.err", rsp_dat.err, e.err);
          slot_taken.delete(cyc);
        end
      end
      dly = req.adr[REG_SEL_BIT] ? REG_DLY : MEM_DLY;
      // ready follows the slot rule alone
      if (vld) begin
        check("rdy", rdy, !slot_taken.exists(cyc + dly));
        if (!rdy && req.adr[REG_SEL_BIT] && last_mem_acc) begin
          n_stall++;
        end
      end
      taken        = vld && rdy;
      last_mem_acc = taken && !req.adr[REG_SEL_BIT];
      if (taken) begin
        e     = apply_model(req);
        e.cyc = cyc + dly;
        exp_q.push_back(e);
        slot_taken[cyc + dly] = 1'b1;
      end
      cyc++;
    end
  end

  ////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////

  initial begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("timeout, responses did not finish within %0d cycles", TIMEOUT_CYC);
    end_with_failure();
  end

  ////////////////////////////////////////
  // main sequence driven on falling edges
  ////////////////////////////////////////

  initial begin
    reset         = 1'b1;
    vld           = 1'b0;
    req           = '0;
    scratch_model = '0;
    count_model   = '0;
    n_issued      = 0;
    n_stall       = 0;
    void'($urandom(32'h316e));
    repeat (5) @(posedge tcb);
    @(negedge tcb);
    reset = 1'b0;
    // idle after reset with ready high and no response
    repeat (3) begin
      @(negedge tcb);
      check("rdy", rdy, 1'b1);
      check("rsp", rsp, 1'b0);
    end
    while (n_issued < N_TRN || (vld && !taken)) begin
      @(negedge tcb);
      if (!vld || taken) begin
        if (n_issued < N_TRN && ($urandom % 4 != 0)) begin
          req   = make_req();
          vld   = 1'b1;
          taken = 1'b0;
          n_issued++;
        end else begin
          vld = 1'b0;
        end
      end
    end
    // drain then watch for stray responses
    while (exp_q.size() != 0) begin
      @(negedge tcb);
    end
    repeat (MEM_DLY + 2) @(negedge tcb);
    if (n_stall == 0) begin
      $display("no register request was stalled behind a memory transfer");
      end_with_failure();
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule : tcb_subsystem_tb

// File: vlog.f
logic/tcb_pkg.sv
logic/tcb_rsp_pipe.sv
logic/tcb_mem_sub.sv
logic/tcb_reg_sub.sv
logic/tcb_dec.sv
logic/tcb_subsystem.sv
test/tcb_clk_gen.sv
test/tcb_subsystem_assert.sv
test/tcb_subsystem_tb.sv
